// File: hdl/mem_pkg.sv
package mem_pkg;

// Load queue
localparam int LDQ_ENTRIES   = 8;
localparam int LDQ_ID_BITS   = $clog2(LDQ_ENTRIES);

// Word addressed data array
localparam int ADDR_BITS     = 6;
localparam int MEM_WORDS     = 1 << ADDR_BITS;
localparam int DATA_BITS     = 32;
localparam int TAG_BITS      = 5;

// Cache line geometry
localparam int LINE_WORDS    = 4;
localparam int LINE_OFS_BITS = $clog2(LINE_WORDS);
localparam int LINES         = 16;
localparam int LINE_IDX_BITS = $clog2(LINES);

// Fill latency from acceptance to line present
localparam int FILL_CYCLES   = 20;
localparam int FILL_CNT_BITS = $clog2(FILL_CYCLES + 1);

typedef logic [LDQ_ID_BITS-1:0]   t_ldq_id;
typedef logic [ADDR_BITS-1:0]     t_mem_addr;
typedef logic [DATA_BITS-1:0]     t_mem_data;
typedef logic [TAG_BITS-1:0]      t_ld_tag;
typedef logic [LINE_IDX_BITS-1:0] t_line_idx;
typedef logic [FILL_CNT_BITS-1:0] t_fill_cnt;

typedef enum logic [1:0] {
    LDQ_IDLE,
    LDQ_REQ_PIPE,
    LDQ_PDG_PIPE,
    LDQ_WAIT
} t_ldq_fsm;

// Line index is the address above the word offset
function automatic t_line_idx line_of(input t_mem_addr addr);
    return addr[ADDR_BITS-1:LINE_OFS_BITS];
endfunction

endpackage

// File: hdl/loadq_entry.sv
`timescale 1ns/100ps

module loadq_entry
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      nuke,
    input  t_ldq_id   id,

    input  logic      alloc,
    input  t_mem_addr alloc_addr,
    input  t_ld_tag   alloc_tag,

    input  logic      pipe_gnt_mm0,

    input  logic      pipe_valid_mm5,
    input  t_ldq_id   pipe_id_mm5,
    input  logic      pipe_complete_mm5,
    input  logic      pipe_recycle_mm5,

    output logic      e_valid,
    output logic      e_pipe_req_mm0,
    output t_mem_addr e_addr,
    output t_ld_tag   e_tag
);

logic     e_action_mm5;
logic     e_complete_mm5;
logic     e_recycle_mm5;
t_ldq_fsm fsm;
t_ldq_fsm fsm_nxt;

// Only the entry named at mm5 reacts to the pipeline action
assign e_action_mm5   = pipe_valid_mm5 & (pipe_id_mm5 == id);
assign e_complete_mm5 = e_action_mm5 & pipe_complete_mm5;
assign e_recycle_mm5  = e_action_mm5 & pipe_recycle_mm5;

always_comb begin
    fsm_nxt = fsm;
    if (nuke) begin
        fsm_nxt = LDQ_IDLE;
    end else begin
        unique case (fsm)
            LDQ_IDLE:     if (alloc) fsm_nxt = LDQ_REQ_PIPE;
            LDQ_REQ_PIPE: if (pipe_gnt_mm0) fsm_nxt = LDQ_PDG_PIPE;
            LDQ_PDG_PIPE: begin
                if (e_complete_mm5) begin
                    fsm_nxt = LDQ_IDLE;
                end else if (e_recycle_mm5) begin
                    fsm_nxt = LDQ_WAIT;
                end
            end
            // One bubble before asking again
            LDQ_WAIT:     fsm_nxt = LDQ_REQ_PIPE;
            default:      fsm_nxt = LDQ_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        fsm <= LDQ_IDLE;
    end else begin
        fsm <= fsm_nxt;
    end
end

// Static fields captured once per load
always_ff @(posedge clk) begin
    if (alloc) begin
        e_addr <= alloc_addr;
        e_tag  <= alloc_tag;
    end
end

assign e_valid        = (fsm != LDQ_IDLE);
assign e_pipe_req_mm0 = (fsm == LDQ_REQ_PIPE);

a_alloc_when_valid: assert property (@(posedge clk) disable iff (reset)
    alloc |-> !e_valid)
    else $error("loadq entry %0d allocated while valid", id);

a_gnt_not_requesting: assert property (@(posedge clk) disable iff (reset)
    pipe_gnt_mm0 |-> (fsm == LDQ_REQ_PIPE))
    else $error("loadq entry %0d granted while not requesting", id);

endmodule

// File: hdl/loadq.sv
`timescale 1ns/100ps

module loadq
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      nuke,

    input  logic      alloc_valid,
    input  t_mem_addr alloc_addr,
    input  t_ld_tag   alloc_tag,
    output t_ldq_id   alloc_id,
    output logic      full,

    output logic      pipe_valid_mm0,
    output t_ldq_id   pipe_id_mm0,
    output t_mem_addr pipe_addr_mm0,

    input  logic      pipe_valid_mm5,
    input  t_ldq_id   pipe_id_mm5,
    input  logic      pipe_complete_mm5,
    input  logic      pipe_recycle_mm5,
    input  t_mem_data pipe_data_mm5,

    output logic      ld_result_valid,
    output t_ld_tag   ld_result_tag,
    output t_mem_data ld_result_data
);

logic [LDQ_ENTRIES-1:0] e_valid;
logic [LDQ_ENTRIES-1:0] e_pipe_req_mm0;
t_mem_addr              e_addr [LDQ_ENTRIES];
t_ld_tag                e_tag  [LDQ_ENTRIES];

logic    gnt_valid;
t_ldq_id gnt_id;
t_ldq_id rr_ptr;

// Lowest numbered idle entry takes the next load
always_comb begin
    alloc_id = '0;
    for (int i = LDQ_ENTRIES - 1; i >= 0; i--) begin
        if (!e_valid[i]) begin
            alloc_id = t_ldq_id'(i);
        end
    end
end

assign full = &e_valid;

// Nearest requester after the last grant wins
always_comb begin
    gnt_valid = 1'b0;
    gnt_id    = rr_ptr;
    for (int i = LDQ_ENTRIES; i >= 1; i--) begin
        if (e_pipe_req_mm0[rr_ptr + t_ldq_id'(i)]) begin
            gnt_valid = 1'b1;
            gnt_id    = rr_ptr + t_ldq_id'(i);
        end
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        rr_ptr <= t_ldq_id'(LDQ_ENTRIES - 1);
    end else if (gnt_valid) begin
        rr_ptr <= gnt_id;
    end
end

assign pipe_valid_mm0 = gnt_valid;
assign pipe_id_mm0    = gnt_id;
assign pipe_addr_mm0  = e_addr[gnt_id];

for (genvar i = 0; i < LDQ_ENTRIES; i++) begin : g_entry
    loadq_entry u_entry (
        .clk               (clk),
        .reset             (reset),
        .nuke              (nuke),
        .id                (t_ldq_id'(i)),
        .alloc             (alloc_valid & ~full & (alloc_id == t_ldq_id'(i))),
        .alloc_addr        (alloc_addr),
        .alloc_tag         (alloc_tag),
        .pipe_gnt_mm0      (gnt_valid & (gnt_id == t_ldq_id'(i))),
        .pipe_valid_mm5    (pipe_valid_mm5),
        .pipe_id_mm5       (pipe_id_mm5),
        .pipe_complete_mm5 (pipe_complete_mm5),
        .pipe_recycle_mm5  (pipe_recycle_mm5),
        .e_valid           (e_valid[i]),
        .e_pipe_req_mm0    (e_pipe_req_mm0[i]),
        .e_addr            (e_addr[i]),
        .e_tag             (e_tag[i])
    );
end

// A completion in the nuke cycle belongs to a squashed load
assign ld_result_valid = pipe_valid_mm5 & pipe_complete_mm5 & ~nuke;
assign ld_result_tag   = e_tag[pipe_id_mm5];
assign ld_result_data  = pipe_data_mm5;

a_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
    alloc_valid |-> !full)
    else $error("load allocated while queue full");

endmodule

// File: hdl/mem_pipe.sv
`timescale 1ns/100ps

module mem_pipe
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      nuke,

    input  logic      pipe_valid_mm0,
    input  t_ldq_id   pipe_id_mm0,
    input  t_mem_addr pipe_addr_mm0,

    input  logic      st_valid,
    input  t_mem_addr st_addr,
    input  t_mem_data st_data,

    output t_line_idx lookup_line,
    input  logic      line_present,

    output logic      fill_req,
    output t_line_idx fill_line,

    output logic      pipe_valid_mm5,
    output t_ldq_id   pipe_id_mm5,
    output logic      pipe_complete_mm5,
    output logic      pipe_recycle_mm5,
    output t_mem_data pipe_data_mm5
);

t_mem_data mem [MEM_WORDS];

logic      valid_mm1, valid_mm2, valid_mm3, valid_mm4, valid_mm5;
t_ldq_id   id_mm1, id_mm2, id_mm3, id_mm4, id_mm5;
t_mem_addr addr_mm1, addr_mm2, addr_mm3, addr_mm4, addr_mm5;
logic      present_mm3, present_mm4, present_mm5;
t_mem_data data_mm4, data_mm5;

// Stage valids all squashed by nuke
always_ff @(posedge clk) begin
    if (reset || nuke) begin
        valid_mm1 <= 1'b0;
        valid_mm2 <= 1'b0;
        valid_mm3 <= 1'b0;
        valid_mm4 <= 1'b0;
        valid_mm5 <= 1'b0;
    end else begin
        valid_mm1 <= pipe_valid_mm0;
        valid_mm2 <= valid_mm1;
        valid_mm3 <= valid_mm2;
        valid_mm4 <= valid_mm3;
        valid_mm5 <= valid_mm4;
    end
end

always_ff @(posedge clk) begin
    id_mm1   <= pipe_id_mm0;
    id_mm2   <= id_mm1;
    id_mm3   <= id_mm2;
    id_mm4   <= id_mm3;
    id_mm5   <= id_mm4;
    addr_mm1 <= pipe_addr_mm0;
    addr_mm2 <= addr_mm1;
    addr_mm3 <= addr_mm2;
    addr_mm4 <= addr_mm3;
    addr_mm5 <= addr_mm4;
end

// Presence looked up at mm2 and carried to the decision at mm5
assign lookup_line = line_of(addr_mm2);

always_ff @(posedge clk) begin
    present_mm3 <= line_present;
    present_mm4 <= present_mm3;
    present_mm5 <= present_mm4;
end

// Array read at mm3
always_ff @(posedge clk) begin
    data_mm4 <= mem[addr_mm3];
    data_mm5 <= data_mm4;
end

// Store port
always_ff @(posedge clk) begin
    if (st_valid) begin
        mem[st_addr] <= st_data;
    end
end

assign pipe_valid_mm5    = valid_mm5;
assign pipe_id_mm5       = id_mm5;
assign pipe_complete_mm5 = valid_mm5 & present_mm5;
assign pipe_recycle_mm5  = valid_mm5 & ~present_mm5;
assign pipe_data_mm5     = data_mm5;

// Every recycle asks for its line; the tracker drops it when busy
assign fill_req  = pipe_recycle_mm5;
assign fill_line = line_of(addr_mm5);

// An entry has at most one load in the pipeline
a_id_in_flight: assert property (@(posedge clk) disable iff (reset)
    pipe_valid_mm0 |-> !((valid_mm1 && id_mm1 == pipe_id_mm0)
                      || (valid_mm2 && id_mm2 == pipe_id_mm0)
                      || (valid_mm3 && id_mm3 == pipe_id_mm0)
                      || (valid_mm4 && id_mm4 == pipe_id_mm0)
                      || (valid_mm5 && id_mm5 == pipe_id_mm0)))
    else $error("loadq entry %0d issued while already in flight", pipe_id_mm0);

endmodule

// File: hdl/line_fill.sv
`timescale 1ns/100ps

module line_fill
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  t_line_idx lookup_line,
    output logic      line_present,

    input  logic      fill_req,
    input  t_line_idx fill_line
);

logic [LINES-1:0] present;
logic             busy;
t_line_idx        busy_line;
t_fill_cnt        count;

assign line_present = present[lookup_line];

// Single fill in flight; count reaches one in the cycle before the line appears
always_ff @(posedge clk) begin
    if (reset) begin
        present <= '0;
        busy    <= 1'b0;
        count   <= '0;
    end else if (busy) begin
        if (count == t_fill_cnt'(1)) begin
            present[busy_line] <= 1'b1;
            busy               <= 1'b0;
            count              <= '0;
        end else begin
            count <= count - t_fill_cnt'(1);
        end
    end else if (fill_req) begin
        busy  <= 1'b1;
        count <= t_fill_cnt'(FILL_CYCLES - 1);
    end
end

always_ff @(posedge clk) begin
    if (!busy && fill_req) begin
        busy_line <= fill_line;
    end
end

a_count_while_idle: assert property (@(posedge clk) disable iff (reset)
    !busy |-> (count == '0))
    else $error("fill counter running while idle");

endmodule

// File: hdl/mem_top.sv
`timescale 1ns/100ps

module mem_top
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      alloc_valid,
    input  t_mem_addr alloc_addr,
    input  t_ld_tag   alloc_tag,
    output t_ldq_id   alloc_id,
    output logic      full,

    input  logic      st_valid,
    input  t_mem_addr st_addr,
    input  t_mem_data st_data,

    output logic      ld_result_valid,
    output t_ld_tag   ld_result_tag,
    output t_mem_data ld_result_data,

    input  logic      nuke
);

logic      pipe_valid_mm0;
t_ldq_id   pipe_id_mm0;
t_mem_addr pipe_addr_mm0;
logic      pipe_valid_mm5;
t_ldq_id   pipe_id_mm5;
logic      pipe_complete_mm5;
logic      pipe_recycle_mm5;
t_mem_data pipe_data_mm5;
t_line_idx lookup_line;
logic      line_present;
logic      fill_req;
t_line_idx fill_line;

loadq u_loadq (
    .clk               (clk),
    .reset             (reset),
    .nuke              (nuke),
    .alloc_valid       (alloc_valid),
    .alloc_addr        (alloc_addr),
    .alloc_tag         (alloc_tag),
    .alloc_id          (alloc_id),
    .full              (full),
    .pipe_valid_mm0    (pipe_valid_mm0),
    .pipe_id_mm0       (pipe_id_mm0),
    .pipe_addr_mm0     (pipe_addr_mm0),
    .pipe_valid_mm5    (pipe_valid_mm5),
    .pipe_id_mm5       (pipe_id_mm5),
    .pipe_complete_mm5 (pipe_complete_mm5),
    .pipe_recycle_mm5  (pipe_recycle_mm5),
    .pipe_data_mm5     (pipe_data_mm5),
    .ld_result_valid   (ld_result_valid),
    .ld_result_tag     (ld_result_tag),
    .ld_result_data    (ld_result_data)
);

mem_pipe u_mem_pipe (
    .clk               (clk),
    .reset             (reset),
    .nuke              (nuke),
    .pipe_valid_mm0    (pipe_valid_mm0),
    .pipe_id_mm0       (pipe_id_mm0),
    .pipe_addr_mm0     (pipe_addr_mm0),
    .st_valid          (st_valid),
    .st_addr           (st_addr),
    .st_data           (st_data),
    .lookup_line       (lookup_line),
    .line_present      (line_present),
    .fill_req          (fill_req),
    .fill_line         (fill_line),
    .pipe_valid_mm5    (pipe_valid_mm5),
    .pipe_id_mm5       (pipe_id_mm5),
    .pipe_complete_mm5 (pipe_complete_mm5),
    .pipe_recycle_mm5  (pipe_recycle_mm5),
    .pipe_data_mm5     (pipe_data_mm5)
);

line_fill u_line_fill (
    .clk          (clk),
    .reset        (reset),
    .lookup_line  (lookup_line),
    .line_present (line_present),
    .fill_req     (fill_req),
    .fill_line    (fill_line)
);

endmodule

// File: testbench/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic fail_run(input string what);
    error_count++;
    $display("ERROR at %0t: %s", $time, what);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
endtask

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
        error_count++;
        $display("FAIL at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
        $display("test failed");
        $fatal(1, "simulation stopped on mismatch");
    end
endtask

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Inputs change a little after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
endtask

task automatic clear_scoreboard();
    for (int t = 0; t < TAGS; t++) begin
        exp_pending[t] = 1'b0;
        exp_data[t]    = '0;
        res_seen[t]    = 0;
        res_cyc[t]     = 0;
    end
    result_count = 0;
endtask

task automatic store_word(input t_mem_addr addr, input t_mem_data data);
    st_valid      = 1'b1;
    st_addr       = addr;
    st_data       = data;
    ref_mem[addr] = data;
    next_cycle();
    st_valid = 1'b0;
endtask

task automatic alloc_load(input t_mem_addr addr, input t_ld_tag tag,
                          output t_ldq_id id, output int at_cyc);
    check_equal(32'(full), 32'd0, "allocation attempted while full");
    exp_pending[tag] = 1'b1;
    exp_data[tag]    = ref_mem[addr];
    alloc_valid = 1'b1;
    alloc_addr  = addr;
    alloc_tag   = tag;
    id          = alloc_id;
    at_cyc      = cyc;
    next_cycle();
    alloc_valid = 1'b0;
endtask

task automatic wait_results(input int count, input int limit);
    int waited;
    waited = 0;
    while (result_count < count) begin
        if (waited >= limit) begin
            fail_run($sformatf("timed out after %0d cycles waiting for %0d results",
                               limit, count));
        end
        next_cycle();
        waited++;
    end
endtask

task automatic preload_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
        store_word(t_mem_addr'(a), lcg_next());
    end
endtask

task automatic test_reset();
    for (int i = 0; i < 10; i++) begin
        check_equal(32'(full), 32'd0, "full after reset");
        check_equal(32'(ld_result_valid), 32'd0, "ld_result_valid after reset");
        next_cycle();
    end
endtask

task automatic test_miss_then_hit();
    t_ldq_id id;
    int      at_cyc;
    clear_scoreboard();
    store_word(6'h02, 32'hcafe_0102);
    alloc_load(6'h02, 5'd3, id, at_cyc);
    wait_results(1, MISS_LIMIT);
    check_equal(32'(res_seen[3]), 32'd1, "miss load result count");
    // Line 0 is present now, so this one hits
    alloc_load(6'h01, 5'd4, id, at_cyc);
    wait_results(2, MISS_LIMIT);
    check_equal(32'(res_seen[4]), 32'd1, "hit load result count");
    check_equal(32'(res_cyc[4]), 32'(at_cyc + 6), "hit latency in cycles");
endtask

task automatic test_full_queue();
    t_ldq_id id;
    int      at_cyc;
    clear_scoreboard();
    // Lines 2 to 9 are still absent
    for (int i = 0; i < LDQ_ENTRIES; i++) begin
        alloc_load({t_line_idx'(i + 2), LINE_OFS_BITS'(i)}, t_ld_tag'(i + 8), id, at_cyc);
        check_equal(32'(id), 32'(i), "alloc_id while filling the queue");
    end
    check_equal(32'(full), 32'd1, "full after eight allocations");
    wait_results(LDQ_ENTRIES, FULL_LIMIT);
    for (int i = 0; i < LDQ_ENTRIES; i++) begin
        check_equal(32'(res_seen[i + 8]), 32'd1,
                    $sformatf("result count for tag %0d", i + 8));
    end
    check_equal(32'(full), 32'd0, "full after all loads completed");
endtask

task automatic test_nuke();
    t_ldq_id id;
    int      at_cyc;
    clear_scoreboard();
    for (int i = 0; i < 3; i++) begin
        alloc_load({t_line_idx'(i + 10), LINE_OFS_BITS'(1)}, t_ld_tag'(i + 16), id, at_cyc);
    end
    next_cycle();
    nuke = 1'b1;
    next_cycle();
    nuke = 1'b0;
    // Squashed loads are no longer expected
    clear_scoreboard();
    for (int i = 0; i < NUKE_QUIET; i++) begin
        check_equal(32'(full), 32'd0, "full after nuke");
        check_equal(32'(result_count), 32'd0, "results after nuke");
        next_cycle();
    end
    // An empty queue hands out entry 0 first
    alloc_load({t_line_idx'(10), LINE_OFS_BITS'(1)}, 5'd20, id, at_cyc);
    check_equal(32'(id), 32'd0, "alloc_id after nuke");
    wait_results(1, MISS_LIMIT);
    check_equal(32'(res_seen[20]), 32'd1, "load after nuke result count");
endtask

task automatic test_random_mix();
    logic [TAGS-1:0] used;
    logic [31:0]     r;
    t_ldq_id         id;
    t_ld_tag         tag;
    int              at_cyc;
    int              issued;
    int              waited;
    clear_scoreboard();
    used = '0;
    for (int i = 0; i < RAND_STORES; i++) begin
        r = lcg_next();
        store_word(r[31:26], lcg_next());
    end
    issued = 0;
    waited = 0;
    while (issued < RAND_LOADS) begin
        if (waited > RAND_LIMIT) begin
            fail_run("random loads could not all be allocated in time");
        end
        if (!full) begin
            do begin
                r   = lcg_next();
                tag = r[31:27];
            end while (used[tag]);
            used[tag] = 1'b1;
            alloc_load(r[21:16], tag, id, at_cyc);
            issued++;
        end else begin
            next_cycle();
        end
        waited++;
    end
    wait_results(RAND_LOADS, RAND_LIMIT);
    for (int t = 0; t < TAGS; t++) begin
        check_equal(32'(res_seen[t]), 32'(used[t]),
                    $sformatf("result count for tag %0d", t));
    end
endtask

`endif

// File: testbench/tb_mem_top.sv
`timescale 1ns/100ps

module tb_mem_top
    import mem_pkg::*;
();

localparam int CLK_PERIOD   = 100;
localparam int DRIVE_DLY    = 10;
localparam int RESET_CYCLES = 16;
localparam int TAGS         = 1 << TAG_BITS;
localparam int RAND_STORES  = 16;
localparam int RAND_LOADS   = 24;

// Cycle budgets per wait sized for fills that run one after another
localparam int MISS_LIMIT  = 2 * FILL_CYCLES + 32;
localparam int FULL_LIMIT  = LDQ_ENTRIES * (FILL_CYCLES + 24);
localparam int NUKE_QUIET  = 8 * FILL_CYCLES;
localparam int RAND_LIMIT  = RAND_LOADS * (FILL_CYCLES + 24);
localparam int TEST_CYCLES = RESET_CYCLES + MEM_WORDS + 10
                           + 2 * MISS_LIMIT + 8
                           + LDQ_ENTRIES + FULL_LIMIT
                           + 8 + NUKE_QUIET + MISS_LIMIT
                           + RAND_STORES + 2 * RAND_LIMIT;
localparam int WATCHDOG_CYCLES = TEST_CYCLES + 8 * FILL_CYCLES;

logic      clk = 1'b0;
logic      reset;
logic      alloc_valid;
t_mem_addr alloc_addr;
t_ld_tag   alloc_tag;
t_ldq_id   alloc_id;
logic      full;
logic      st_valid;
t_mem_addr st_addr;
t_mem_data st_data;
logic      ld_result_valid;
t_ld_tag   ld_result_tag;
t_mem_data ld_result_data;
logic      nuke;

// Mirror of the data array
t_mem_data ref_mem [MEM_WORDS];

// Scoreboard indexed by load tag
logic      exp_pending [TAGS];
t_mem_data exp_data    [TAGS];
int        res_seen    [TAGS];
int        res_cyc     [TAGS];
int        result_count;

int          cyc = 0;
int          error_count;
logic [31:0] lcg_state;

mem_top DUT (
    .clk             (clk),
    .reset           (reset),
    .alloc_valid     (alloc_valid),
    .alloc_addr      (alloc_addr),
    .alloc_tag       (alloc_tag),
    .alloc_id        (alloc_id),
    .full            (full),
    .st_valid        (st_valid),
    .st_addr         (st_addr),
    .st_data         (st_data),
    .ld_result_valid (ld_result_valid),
    .ld_result_tag   (ld_result_tag),
    .ld_result_data  (ld_result_data),
    .nuke            (nuke)
);

`include "tb_tasks.svh"

always #(CLK_PERIOD / 2) clk = ~clk;

always @(posedge clk) begin
    cyc <= cyc + 1;
end

// Results sampled mid-cycle
always @(negedge clk) begin
    if (!reset && ld_result_valid) begin
        check_equal(32'(exp_pending[ld_result_tag]), 32'd1,
                    $sformatf("result for tag %0d not in flight", ld_result_tag));
        check_equal(ld_result_data, exp_data[ld_result_tag],
                    $sformatf("data returned for tag %0d", ld_result_tag));
        exp_pending[ld_result_tag] = 1'b0;
        res_seen[ld_result_tag]++;
        res_cyc[ld_result_tag] = cyc;
        result_count++;
    end
end

initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
end

initial begin
    reset       = 1'b1;
    alloc_valid = 1'b0;
    alloc_addr  = '0;
    alloc_tag   = '0;
    st_valid    = 1'b0;
    st_addr     = '0;
    st_data     = '0;
    nuke        = 1'b0;
    error_count = 0;
    lcg_state   = 32'h304d_2f9b;
    clear_scoreboard();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;

    test_reset();
    preload_memory();
    test_miss_then_hit();
    test_full_queue();
    test_nuke();
    test_random_mix();

    if (error_count == 0) begin
        $display("test passed");
    end else begin
        $display("test failed");
    end
    $finish;
end

endmodule

// File: list.f
+incdir+testbench
hdl/mem_pkg.sv
hdl/loadq_entry.sv
hdl/loadq.sv
hdl/mem_pipe.sv
hdl/line_fill.sv
hdl/mem_top.sv
testbench/tb_mem_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
